//--- hdl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath width
`define XLEN 32

// register address width
`define REGW 5

`endif

//--- hdl/rvPkg.sv
`default_nettype none

package rvPkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OPIMM  = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU // branch compares
	} aluOpT;

	// order follows funct3[1:0] of the M extension
	typedef enum logic [1:0] {
		MUL_MUL,
		MUL_MULH,
		MUL_MULHSU,
		MUL_MULHU
	} mulOpT;

	typedef enum logic [2:0] {
		WB_ALU,
		WB_LINK,   // pc + 4
		WB_MUL,
		WB_UPPER,  // lui
		WB_AUIPC,
		WB_NONE
	} wbSelT;

endpackage

`default_nettype wire

//--- hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module aluUnit (
	input  rvPkg::aluOpT      aluOp,
	input  logic [`XLEN-1:0]  a,
	input  logic [`XLEN-1:0]  b,
	output logic [`XLEN-1:0]  result,
	output logic              cond
);

	logic [$clog2(`XLEN)-1:0] shamt;
	logic eq;
	logic lt;
	logic ltu;

	assign shamt = b[$clog2(`XLEN)-1:0];
	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb
	begin
		case (aluOp)
			rvPkg::ALU_ADD:  result = a + b;
			rvPkg::ALU_SUB:  result = a - b;
			rvPkg::ALU_AND:  result = a & b;
			rvPkg::ALU_OR:   result = a | b;
			rvPkg::ALU_XOR:  result = a ^ b;
			rvPkg::ALU_SLL:  result = a << shamt;
			rvPkg::ALU_SRL:  result = a >> shamt;
			rvPkg::ALU_SRA:  result = $signed(a) >>> shamt;
			rvPkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt};
			rvPkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, ltu};
			default:         result = '0; // branch compares only drive cond
		endcase
	end

	always_comb
	begin
		case (aluOp)
			rvPkg::ALU_EQ:  cond = eq;
			rvPkg::ALU_NE:  cond = !eq;
			rvPkg::ALU_LT:  cond = lt;
			rvPkg::ALU_GE:  cond = !lt;
			rvPkg::ALU_LTU: cond = ltu;
			rvPkg::ALU_GEU: cond = !ltu;
			default:        cond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module branchUnit (
	input  logic [`XLEN-1:0]  pc,
	input  logic [`XLEN-1:0]  opA,
	input  logic [`XLEN-1:0]  imm,
	input  logic              cond,
	input  logic              isBranch,
	input  logic              isJal,
	input  logic              isJalr,
	output logic              taken,
	output logic [`XLEN-1:0]  target
);

	logic [`XLEN-1:0] jalrSum;

	assign jalrSum = opA + imm;

	// jumps always go
	assign taken = isJal || isJalr || (isBranch && cond);

	assign target = isJalr ? {jalrSum[`XLEN-1:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

//--- hdl/mulUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module mulUnit (
	input  rvPkg::mulOpT      mulOp,
	input  logic [`XLEN-1:0]  a,
	input  logic [`XLEN-1:0]  b,
	output logic [`XLEN-1:0]  result
);

	logic aSigned;
	logic bSigned;
	logic [2*`XLEN-1:0] aExt;
	logic [2*`XLEN-1:0] bExt;
	logic [2*`XLEN-1:0] product;

	assign aSigned = (mulOp == rvPkg::MUL_MULH) || (mulOp == rvPkg::MUL_MULHSU);
	assign bSigned = (mulOp == rvPkg::MUL_MULH);

	// extend to full width so the low 64 bits hold the right product
	assign aExt = {{`XLEN{aSigned & a[`XLEN-1]}}, a};
	assign bExt = {{`XLEN{bSigned & b[`XLEN-1]}}, b};
	assign product = aExt * bExt;

	assign result = (mulOp == rvPkg::MUL_MUL) ? product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];

endmodule

`default_nettype wire

//--- hdl/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module instrDecode (
	input  logic               clk,
	input  logic               nrst,
	input  logic               inValid,
	output logic               inReady,
	input  logic [31:0]        instr,
	input  logic [`XLEN-1:0]   pc,
	input  logic [`XLEN-1:0]   rs1Data,
	input  logic [`XLEN-1:0]   rs2Data,
	output logic               decValid,
	input  logic               decReady,
	output logic [`REGW-1:0]   rd,
	output logic               regWe,
	output rvPkg::aluOpT       aluOp,
	output rvPkg::mulOpT       mulOp,
	output rvPkg::wbSelT       wbSel,
	output logic               isBranch,
	output logic               isJal,
	output logic               isJalr,
	output logic               illegal,
	output logic [`XLEN-1:0]   opA,
	output logic [`XLEN-1:0]   opB,
	output logic [`XLEN-1:0]   cmpB,
	output logic [`XLEN-1:0]   imm,
	output logic [`XLEN-1:0]   decPc
);

	rvPkg::opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] immI, immU, immB, immJ;

	logic [`XLEN-1:0] immN;
	logic useImm;
	logic weN;
	logic illegalN;
	logic isBranchN, isJalN, isJalrN;
	rvPkg::aluOpT aluOpN;
	rvPkg::mulOpT mulOpN;
	rvPkg::wbSelT wbSelN;

	assign opcode = rvPkg::opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immU = {instr[31:12], 12'b0};
	assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign inReady = !decValid || decReady;

	always_comb
	begin
		immN = '0;
		useImm = 1'b0;
		weN = 1'b0;
		illegalN = 1'b0;
		isBranchN = 1'b0;
		isJalN = 1'b0;
		isJalrN = 1'b0;
		aluOpN = rvPkg::ALU_ADD;
		mulOpN = rvPkg::MUL_MUL;
		wbSelN = rvPkg::WB_NONE;
		case (opcode)
			rvPkg::OPC_OP, rvPkg::OPC_OPIMM:
			begin
				useImm = (opcode == rvPkg::OPC_OPIMM);
				immN = immI;
				weN = 1'b1;
				wbSelN = rvPkg::WB_ALU;
				case (funct3)
					3'b000: aluOpN = (!useImm && funct7[5]) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
					3'b001: aluOpN = rvPkg::ALU_SLL;
					3'b010: aluOpN = rvPkg::ALU_SLT;
					3'b011: aluOpN = rvPkg::ALU_SLTU;
					3'b100: aluOpN = rvPkg::ALU_XOR;
					3'b101: aluOpN = funct7[5] ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
					3'b110: aluOpN = rvPkg::ALU_OR;
					default: aluOpN = rvPkg::ALU_AND;
				endcase
				if (!useImm && funct7 == 7'b0000001)
				begin
					wbSelN = rvPkg::WB_MUL;
					mulOpN = rvPkg::mulOpT'(funct3[1:0]);
					if (funct3[2]) // division not supported
					begin
						illegalN = 1'b1;
						weN = 1'b0;
						wbSelN = rvPkg::WB_NONE;
					end
				end
			end
			rvPkg::OPC_LUI:
			begin
				immN = immU;
				weN = 1'b1;
				wbSelN = rvPkg::WB_UPPER;
			end
			rvPkg::OPC_AUIPC:
			begin
				immN = immU;
				weN = 1'b1;
				wbSelN = rvPkg::WB_AUIPC;
			end
			rvPkg::OPC_JAL:
			begin
				immN = immJ;
				isJalN = 1'b1;
				weN = 1'b1;
				wbSelN = rvPkg::WB_LINK;
			end
			rvPkg::OPC_JALR:
			begin
				immN = immI;
				isJalrN = 1'b1;
				weN = 1'b1;
				wbSelN = rvPkg::WB_LINK;
			end
			rvPkg::OPC_BRANCH:
			begin
				immN = immB;
				isBranchN = 1'b1;
				case (funct3)
					3'b000: aluOpN = rvPkg::ALU_EQ;
					3'b001: aluOpN = rvPkg::ALU_NE;
					3'b100: aluOpN = rvPkg::ALU_LT;
					3'b101: aluOpN = rvPkg::ALU_GE;
					3'b110: aluOpN = rvPkg::ALU_LTU;
					3'b111: aluOpN = rvPkg::ALU_GEU;
					default:
					begin
						isBranchN = 1'b0; // 010/011 are not branches
						illegalN = 1'b1;
					end
				endcase
			end
			default: illegalN = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			decValid <= 1'b0;
		else if (inReady)
			decValid <= inValid;
	end

	// payload only loads on a transfer
	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
		begin
			rd <= instr[11:7];
			regWe <= weN && (instr[11:7] != '0); // x0 never written
			aluOp <= aluOpN;
			mulOp <= mulOpN;
			wbSel <= wbSelN;
			isBranch <= isBranchN;
			isJal <= isJalN;
			isJalr <= isJalrN;
			illegal <= illegalN;
			opA <= rs1Data;
			opB <= useImm ? immN : rs2Data;
			cmpB <= rs2Data;
			imm <= immN;
			decPc <= pc;
		end
	end

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module executeStage (
	input  logic              clk,
	input  logic              nrst,
	input  logic              decValid,
	output logic              decReady,
	input  logic [`REGW-1:0]  decRd,
	input  logic              decRegWe,
	input  rvPkg::aluOpT      decAluOp,
	input  rvPkg::mulOpT      decMulOp,
	input  rvPkg::wbSelT      decWbSel,
	input  logic              decIsBranch,
	input  logic              decIsJal,
	input  logic              decIsJalr,
	input  logic              decIllegal,
	input  logic [`XLEN-1:0]  decOpA,
	input  logic [`XLEN-1:0]  decOpB,
	input  logic [`XLEN-1:0]  decCmpB,
	input  logic [`XLEN-1:0]  decImm,
	input  logic [`XLEN-1:0]  decPc,
	output logic              exeValid,
	input  logic              exeReady,
	output logic [`XLEN-1:0]  aluRes,
	output logic [`XLEN-1:0]  mulRes,
	output logic [`XLEN-1:0]  linkAddr,
	output logic [`XLEN-1:0]  auipcRes,
	output logic [`XLEN-1:0]  upperImm,
	output rvPkg::wbSelT      wbSel,
	output logic [`REGW-1:0]  rd,
	output logic              regWe,
	output logic              illegal,
	output logic              taken,
	output logic [`XLEN-1:0]  target
);

	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluOut;
	logic aluCond;
	logic [`XLEN-1:0] mulOut;
	logic takenN;
	logic [`XLEN-1:0] targetN;

	assign decReady = !exeValid || exeReady;

	// branches compare against rs2, not the immediate
	assign aluB = decIsBranch ? decCmpB : decOpB;

	aluUnit alu (
		.aluOp  (decAluOp),
		.a      (decOpA),
		.b      (aluB),
		.result (aluOut),
		.cond   (aluCond)
	);

	branchUnit bru (
		.pc       (decPc),
		.opA      (decOpA),
		.imm      (decImm),
		.cond     (aluCond),
		.isBranch (decIsBranch),
		.isJal    (decIsJal),
		.isJalr   (decIsJalr),
		.taken    (takenN),
		.target   (targetN)
	);

	mulUnit mul (
		.mulOp  (decMulOp),
		.a      (decOpA),
		.b      (decOpB),
		.result (mulOut)
	);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			exeValid <= 1'b0;
		else if (decReady)
			exeValid <= decValid;
	end

	always_ff @(posedge clk)
	begin
		if (decValid && decReady)
		begin
			aluRes <= aluOut;
			mulRes <= mulOut;
			linkAddr <= decPc + `XLEN'd4; // byte addressed
			auipcRes <= decPc + decImm;
			upperImm <= decImm;
			wbSel <= decWbSel;
			rd <= decRd;
			regWe <= decRegWe;
			illegal <= decIllegal;
			taken <= takenN;
			target <= targetN;
		end
	end

endmodule

`default_nettype wire

//--- hdl/resultSelect.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module resultSelect (
	input  logic              clk,
	input  logic              nrst,
	input  logic              exeValid,
	output logic              exeReady,
	input  logic [`XLEN-1:0]  aluRes,
	input  logic [`XLEN-1:0]  mulRes,
	input  logic [`XLEN-1:0]  linkAddr,
	input  logic [`XLEN-1:0]  auipcRes,
	input  logic [`XLEN-1:0]  upperImm,
	input  rvPkg::wbSelT      wbSel,
	input  logic [`REGW-1:0]  rd,
	input  logic              exeRegWe,
	input  logic              exeIllegal,
	input  logic              taken,
	input  logic [`XLEN-1:0]  target,
	output logic              outValid,
	input  logic              outReady,
	output logic [`REGW-1:0]  rdAddr,
	output logic [`XLEN-1:0]  rdData,
	output logic              regWe,
	output logic              redirect,
	output logic [`XLEN-1:0]  redirectTarget,
	output logic              illegal
);

	logic [`XLEN-1:0] wbData;
	logic regWeQ;
	logic redirectQ;
	logic illegalQ;
	logic load;

	assign exeReady = !outValid || outReady;
	assign load = exeValid && exeReady;

	always_comb
	begin
		case (wbSel)
			rvPkg::WB_ALU:   wbData = aluRes;
			rvPkg::WB_LINK:  wbData = linkAddr;
			rvPkg::WB_MUL:   wbData = mulRes;
			rvPkg::WB_UPPER: wbData = upperImm;
			rvPkg::WB_AUIPC: wbData = auipcRes;
			default:         wbData = '0;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			outValid <= 1'b0;
			regWeQ <= 1'b0;
			redirectQ <= 1'b0;
			illegalQ <= 1'b0;
		end
		else
		begin
			if (exeReady)
				outValid <= exeValid;
			if (load)
			begin
				regWeQ <= exeRegWe && (wbSel != rvPkg::WB_NONE);
				redirectQ <= taken;
				illegalQ <= exeIllegal;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			rdAddr <= rd;
			rdData <= wbData;
			redirectTarget <= target;
		end
	end

	// flags only show with a valid result
	assign regWe = regWeQ && outValid;
	assign redirect = redirectQ && outValid;
	assign illegal = illegalQ && outValid;

endmodule

`default_nettype wire

//--- hdl/exeCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module exeCore (
	input  logic              clk,
	input  logic              nrst,
	input  logic              inValid,
	output logic              inReady,
	input  logic [31:0]       instr,
	input  logic [`XLEN-1:0]  pc,
	input  logic [`XLEN-1:0]  rs1Data,
	input  logic [`XLEN-1:0]  rs2Data,
	output logic              outValid,
	input  logic              outReady,
	output logic [`REGW-1:0]  rdAddr,
	output logic [`XLEN-1:0]  rdData,
	output logic              regWe,
	output logic              redirect,
	output logic [`XLEN-1:0]  redirectTarget,
	output logic              illegal
);

	// decode to execute
	logic decValid, exeReady;
	logic [`REGW-1:0] decRd;
	logic decRegWe, decIsBranch, decIsJal, decIsJalr, decIllegal;
	rvPkg::aluOpT decAluOp;
	rvPkg::mulOpT decMulOp;
	rvPkg::wbSelT decWbSel;
	logic [`XLEN-1:0] decOpA, decOpB, decCmpB, decImm, decPc;

	// execute to result
	logic exeValid, resReady;
	logic [`XLEN-1:0] aluRes, mulRes, linkAddr, auipcRes, upperImm, target;
	rvPkg::wbSelT exeWbSel;
	logic [`REGW-1:0] exeRd;
	logic exeRegWe, exeIllegal, exeTaken;

	instrDecode decode (
		.clk(clk), .nrst(nrst),
		.inValid(inValid), .inReady(inReady),
		.instr(instr), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.decValid(decValid), .decReady(exeReady),
		.rd(decRd), .regWe(decRegWe), .aluOp(decAluOp), .mulOp(decMulOp),
		.wbSel(decWbSel), .isBranch(decIsBranch), .isJal(decIsJal),
		.isJalr(decIsJalr), .illegal(decIllegal), .opA(decOpA), .opB(decOpB),
		.cmpB(decCmpB), .imm(decImm), .decPc(decPc)
	);

	executeStage execute (
		.clk(clk), .nrst(nrst),
		.decValid(decValid), .decReady(exeReady),
		.decRd(decRd), .decRegWe(decRegWe), .decAluOp(decAluOp),
		.decMulOp(decMulOp), .decWbSel(decWbSel), .decIsBranch(decIsBranch),
		.decIsJal(decIsJal), .decIsJalr(decIsJalr), .decIllegal(decIllegal),
		.decOpA(decOpA), .decOpB(decOpB), .decCmpB(decCmpB), .decImm(decImm),
		.decPc(decPc),
		.exeValid(exeValid), .exeReady(resReady),
		.aluRes(aluRes), .mulRes(mulRes), .linkAddr(linkAddr),
		.auipcRes(auipcRes), .upperImm(upperImm), .wbSel(exeWbSel),
		.rd(exeRd), .regWe(exeRegWe), .illegal(exeIllegal),
		.taken(exeTaken), .target(target)
	);

	resultSelect result (
		.clk(clk), .nrst(nrst),
		.exeValid(exeValid), .exeReady(resReady),
		.aluRes(aluRes), .mulRes(mulRes), .linkAddr(linkAddr),
		.auipcRes(auipcRes), .upperImm(upperImm), .wbSel(exeWbSel),
		.rd(exeRd), .exeRegWe(exeRegWe), .exeIllegal(exeIllegal),
		.taken(exeTaken), .target(target),
		.outValid(outValid), .outReady(outReady),
		.rdAddr(rdAddr), .rdData(rdData), .regWe(regWe),
		.redirect(redirect), .redirectTarget(redirectTarget), .illegal(illegal)
	);

endmodule

`default_nettype wire

//--- tests/exeCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module exeCoreTb;

	localparam int maxCycles = 3000; // 400 instrs with stalls, doubled, plus margin

	typedef struct packed {
		logic [`REGW-1:0] rd;
		logic we;
		logic [`XLEN-1:0] data;
		logic redir;
		logic [`XLEN-1:0] target;
		logic ill;
		logic [31:0] inCycle;
		logic fast; // accepted while outReady was held high
	} expT;

	logic clk;
	logic nrst;
	logic inValid;
	logic inReady;
	logic [31:0] instr;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	logic outValid;
	logic outReady;
	logic [`REGW-1:0] rdAddr;
	logic [`XLEN-1:0] rdData;
	logic regWe;
	logic redirect;
	logic [`XLEN-1:0] redirectTarget;
	logic illegal;

	expT expQ[$];
	expT pendExp; // model result for the instruction being offered
	expT popped;
	logic [71:0] heldOut;
	logic holdPending;
	logic inFire;
	logic fastPhase;
	int cycles;
	int errors;
	int checked;

	exeCore dut (
		.clk(clk), .nrst(nrst),
		.inValid(inValid), .inReady(inReady),
		.instr(instr), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.outValid(outValid), .outReady(outReady),
		.rdAddr(rdAddr), .rdData(rdData), .regWe(regWe),
		.redirect(redirect), .redirectTarget(redirectTarget), .illegal(illegal)
	);

	always #10 clk = !clk;

	task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// integer ops as the ISA defines them
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd5:
			begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// builds a random instruction and its expected result
	task automatic makeInstr;
		int kind;
		int sel;
		logic [31:0] r0, r1, a, b, pcv, res, tgt;
		logic [2:0] f3;
		logic [4:0] rdf, rs1f, rs2f;
		logic [11:0] i12;
		logic [20:0] jimm;
		logic [12:0] bimm;
		logic [6:0] opc;
		logic we, redir, ill, alt;
		longint sa, sb, ua, ub, prod;
		r0 = $urandom;
		r1 = $urandom;
		a = $urandom;
		b = ($urandom % 4 == 0) ? a : $urandom; // equal operands for branches
		if ($urandom % 4 == 0)
			a = a >> 27;
		pcv = $urandom & 32'hffff_fffc;
		rdf = (r0[21:18] == 4'd0) ? 5'd0 : r0[4:0];
		rs1f = r0[9:5];
		rs2f = r0[14:10];
		f3 = r0[17:15];
		alt = r0[22] && (f3 == 3'd0 || f3 == 3'd5);
		jimm = {r1[19:0], 1'b0};
		bimm = {r1[11:0], 1'b0};
		we = 1'b1;
		redir = 1'b0;
		ill = 1'b0;
		tgt = '0;
		res = '0;
		kind = $urandom % 20;
		if (kind < 5)
		begin
			instr = {1'b0, alt, 5'b0, rs2f, rs1f, f3, rdf, rvPkg::OPC_OP};
			res = aluRef(f3, alt, a, b);
		end
		else if (kind < 9)
		begin
			i12 = r1[11:0];
			if (f3 == 3'd1 || f3 == 3'd5)
				i12 = {1'b0, alt && f3 == 3'd5, 5'b0, r1[4:0]}; // shift amount only
			instr = {i12, rs1f, f3, rdf, rvPkg::OPC_OPIMM};
			res = aluRef(f3, alt && f3 == 3'd5, a, {{20{i12[11]}}, i12});
		end
		else if (kind < 11)
		begin
			instr = {7'h01, rs2f, rs1f, 1'b0, f3[1:0], rdf, rvPkg::OPC_OP};
			sa = $signed(a);
			sb = $signed(b);
			ua = {32'b0, a};
			ub = {32'b0, b};
			case (f3[1:0])
				2'd0, 2'd1: prod = sa * sb;
				2'd2: prod = sa * ub;
				default: prod = ua * ub;
			endcase
			res = (f3[1:0] == 2'd0) ? prod[31:0] : prod[63:32];
		end
		else if (kind < 13)
		begin
			instr = {r1[31:12], rdf, (kind == 11) ? rvPkg::OPC_LUI : rvPkg::OPC_AUIPC};
			res = (kind == 11) ? {r1[31:12], 12'b0} : pcv + {r1[31:12], 12'b0};
		end
		else if (kind == 13)
		begin
			instr = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rdf, rvPkg::OPC_JAL};
			res = pcv + 32'd4;
			redir = 1'b1;
			tgt = pcv + {{11{jimm[20]}}, jimm};
		end
		else if (kind == 14)
		begin
			instr = {r1[11:0], rs1f, 3'b000, rdf, rvPkg::OPC_JALR};
			res = pcv + 32'd4;
			redir = 1'b1;
			tgt = (a + {{20{r1[11]}}, r1[11:0]}) & ~32'h1;
		end
		else if (kind < 19)
		begin
			sel = $urandom % 6;
			case (sel)
				0: f3 = 3'b000;
				1: f3 = 3'b001;
				2: f3 = 3'b100;
				3: f3 = 3'b101;
				4: f3 = 3'b110;
				default: f3 = 3'b111;
			endcase
			case (f3)
				3'b000: redir = (a == b);
				3'b001: redir = (a != b);
				3'b100: redir = ($signed(a) < $signed(b));
				3'b101: redir = ($signed(a) >= $signed(b));
				3'b110: redir = (a < b);
				default: redir = (a >= b);
			endcase
			instr = {bimm[12], bimm[10:5], rs2f, rs1f, f3, bimm[4:1], bimm[11],
				rvPkg::OPC_BRANCH};
			we = 1'b0;
			tgt = pcv + {{19{bimm[12]}}, bimm};
		end
		else
		begin
			case ($urandom % 4)
				0: opc = 7'b0000011; // load
				1: opc = 7'b0100011; // store
				2: opc = 7'b0001111;
				default: opc = 7'b1110011;
			endcase
			instr = {r1[24:0], opc};
			we = 1'b0;
			ill = 1'b1;
		end
		pc = pcv;
		rs1Data = a;
		rs2Data = b;
		pendExp = '0;
		pendExp.rd = rdf;
		pendExp.we = we && (rdf != 5'd0);
		pendExp.data = res;
		pendExp.redir = redir;
		pendExp.target = tgt;
		pendExp.ill = ill;
	endtask

	// offers count instructions, then waits for the pipeline to drain
	task automatic runPhase(input int count, input logic randomReady);
		int issued;
		issued = 0;
		while (issued < count || inValid)
		begin
			@(posedge clk);
			#1;
			if (!inValid || inFire)
			begin
				inValid = 1'b0;
				if (issued < count && $urandom % 8 != 0)
				begin
					makeInstr();
					inValid = 1'b1;
					issued++;
				end
			end
			outReady = randomReady ? ($urandom % 3 != 0) : 1'b1;
		end
		while (expQ.size() != 0)
		begin
			@(posedge clk);
			#1;
			outReady = randomReady ? ($urandom % 3 != 0) : 1'b1;
		end
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= maxCycles)
		begin
			$display("timeout after %0d cycles, %0d results still outstanding, %0d errors",
				cycles, expQ.size(), errors);
			$display("Test failures found");
			$finish;
		end
	end

	// outputs and handshakes are sampled mid cycle
	always @(negedge clk)
	begin
		inFire = 1'b0;
		if (!nrst)
		begin
			assert (!outValid && !regWe && !redirect && !illegal && inReady)
			else
			begin
				errors++;
				$display("outputs not idle or input not ready during reset");
			end
		end
		else
		begin
			if (holdPending)
			begin
				assert (outValid && heldOut ===
					{rdAddr, rdData, regWe, redirect, redirectTarget, illegal})
				else
				begin
					errors++;
					$display("ERR held outputs: valid %h, got %h, expected %h", outValid,
						{rdAddr, rdData, regWe, redirect, redirectTarget, illegal}, heldOut);
				end
			end
			holdPending = outValid && !outReady;
			heldOut = {rdAddr, rdData, regWe, redirect, redirectTarget, illegal};
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					errors++;
					$display("result delivered with no instruction outstanding");
				end
				else
				begin
					popped = expQ.pop_front();
					checked++;
					checkField("regWe", {31'b0, regWe}, {31'b0, popped.we});
					if (popped.we)
					begin
						checkField("rdAddr", {27'b0, rdAddr}, {27'b0, popped.rd});
						checkField("rdData", rdData, popped.data);
					end
					checkField("redirect", {31'b0, redirect}, {31'b0, popped.redir});
					if (popped.redir)
						checkField("redirectTarget", redirectTarget, popped.target);
					checkField("illegal", {31'b0, illegal}, {31'b0, popped.ill});
					if (popped.fast)
						checkField("latency", cycles - popped.inCycle, 32'd3);
				end
			end
			inFire = inValid && inReady;
			if (inFire)
			begin
				popped = pendExp;
				popped.inCycle = cycles;
				popped.fast = fastPhase;
				expQ.push_back(popped);
			end
		end
	end

	initial
	begin
		void'($urandom(32'h0c21aca2));
		clk = 1'b0;
		nrst = 1'b0;
		inValid = 1'b0;
		instr = '0;
		pc = '0;
		rs1Data = '0;
		rs2Data = '0;
		outReady = 1'b1;
		pendExp = '0;
		heldOut = '0;
		holdPending = 1'b0;
		inFire = 1'b0;
		fastPhase = 1'b1;
		cycles = 0;
		errors = 0;
		checked = 0;
		repeat (3) @(posedge clk);
		#1;
		nrst = 1'b1;
		runPhase(150, 1'b0); // steady drain, fixed latency
		fastPhase = 1'b0;
		runPhase(250, 1'b1);
		$display("%0d results checked, %0d errors", checked, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/rvPkg.sv
hdl/aluUnit.sv
hdl/branchUnit.sv
hdl/mulUnit.sv
hdl/instrDecode.sv
hdl/executeStage.sv
hdl/resultSelect.sv
hdl/exeCore.sv
tests/exeCoreTb.sv

//--- Bender.yml
package:
  name: exe_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rvPkg.sv
      - hdl/aluUnit.sv
      - hdl/branchUnit.sv
      - hdl/mulUnit.sv
      - hdl/instrDecode.sv
      - hdl/executeStage.sv
      - hdl/resultSelect.sv
      - hdl/exeCore.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/exeCoreTb.sv
